// File: verification/dsp_stim.txt
// Columns: instruction, bus check (1 valid and bus_do, 0 valid low), expected bus_do,
// flag check, expected flags as S Z C V in the low four bits.
// CT0 load, two immediates into MD0, reload, read back with increment.
00001C00 1 00000000 1 0
0000105A 1 0000005A 1 0
000010A5 1 FFFFFFA5 1 0
00001C00 1 00000000 1 0
00003A04 1 0000005A 1 0
00003A04 1 FFFFFFA5 1 0
// CT1 at 63, write, wrap to 0, write, reload and read both.
00001D3F 1 0000003F 1 0
00001171 1 00000071 1 0
00001112 1 00000012 1 0
00001D3F 1 0000003F 1 0
00003A05 1 00000071 1 0
00003A01 1 00000012 1 0
// RX and RY from RAM, MUL P with CLR A, AD2 into A, read ACL and ACH.
00001C01 1 00000001 1 0
02084000 0 00000000 1 0
01020000 0 00000000 1 0
18040000 0 00000000 1 8
00003A09 1 FFFFF99A 1 8
00003A0A 1 0000FFFF 1 8
// ALU ops into A, each word also reads the ACL of the word before.
00021501 1 00000001 1 8
100415FF 1 FFFFFFFF 1 0
10043A09 1 00000001 1 6
14043A09 1 00000000 1 2
24043A09 1 00000001 1 A
10043A09 1 80000000 1 3
28043A09 1 7FFFFFFF 1 9
3C043A09 1 FFFFFFFE 1 B
04043A09 1 FFFFFEFF 1 9
1C043A09 1 FFFFFEFF 1 9
00003A0A 1 00000000 1 9

// File: vlog.f
+incdir+common
common/dsp_pkg.sv
common/dsp_ctrl_if.sv
mac/dsp_alu.sv
mac/dsp_mac.sv
ram/dsp_ram_bank.sv
verilog/dsp_decoder.sv
verilog/dsp_d1_bus.sv
verilog/scu_dsp_top.sv
verification/tb_scu_dsp.sv

// File: verification/tb_scu_dsp.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scu_dsp;

	localparam int MAX_LINES = 64;
	localparam int COLS = 5;	// Instr, bus check, bus_do, flag check, flags.

	logic clock;
	logic arst_n;
	logic instr_valid;
	logic [31:0] instr;
	logic [31:0] bus_do;
	logic bus_do_valid;
	logic s_flag;
	logic z_flag;
	logic c_flag;
	logic v_flag;

	logic [31:0] stim_mem [0:MAX_LINES*COLS-1];
	int line_count;
	int cycle_count;
	int timeout_limit;

	scu_dsp_top dut_i (
		.clock(clock),
		.arst_n(arst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.bus_do(bus_do),
		.bus_do_valid(bus_do_valid),
		.s_flag(s_flag),
		.z_flag(z_flag),
		.c_flag(c_flag),
		.v_flag(v_flag)
	);

	always #20 clock = ~clock;	// 40 ns period.

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	function automatic logic [31:0] flag_word();
		return {28'h0, s_flag, z_flag, c_flag, v_flag};	// S Z C V order.
	endfunction

	task automatic check_line(input int n);
		logic [31:0] bus_chk;
		logic [31:0] bus_exp;
		logic [31:0] flag_chk;
		logic [31:0] flag_exp;
		bus_chk = stim_mem[n*COLS+1];
		bus_exp = stim_mem[n*COLS+2];
		flag_chk = stim_mem[n*COLS+3];
		flag_exp = stim_mem[n*COLS+4];
		if (bus_chk[0]) begin
			check_value($sformatf("line %0d bus_do_valid", n), 32'd1, {31'd0, bus_do_valid});
			check_value($sformatf("line %0d bus_do", n), bus_exp, bus_do);
		end else begin
			// No D1 move, so the strobe stays low.
			check_value($sformatf("line %0d bus_do_valid", n), 32'd0, {31'd0, bus_do_valid});
		end
		if (flag_chk[0])
			check_value($sformatf("line %0d flags", n), flag_exp, flag_word());
	endtask

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_limit)
			abort_run($sformatf("Timeout after %0d cycles before the tests finished",
				cycle_count));
	end

	initial begin
		clock = 1'b0;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		cycle_count = 0;
		line_count = 0;
		timeout_limit = 20;
		$readmemh("verification/dsp_stim.txt", stim_mem);
		while (line_count < MAX_LINES && !$isunknown(stim_mem[line_count*COLS]))
			line_count++;
		if (line_count == 0)
			abort_run("No stimulus lines were read from verification/dsp_stim.txt");
		timeout_limit = 2 * line_count + 20;	// Reset and drain fit in the margin.

		repeat (8) @(negedge clock);
		arst_n = 1'b1;
		check_value("reset bus_do_valid", 32'd0, {31'd0, bus_do_valid});
		check_value("reset flags", 32'd0, flag_word());

		for (int n = 0; n < line_count; n++) begin
			instr = stim_mem[n*COLS];
			instr_valid = 1'b1;
			@(negedge clock);
			check_line(n);	// Results of the edge just passed.
		end
		instr_valid = 1'b0;
		instr = '0;
		@(negedge clock);
		check_value("idle bus_do_valid", 32'd0, {31'd0, bus_do_valid});

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/scu_dsp_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsp_consts.svh"

module scu_dsp_top (
	input wire clock,
	input wire arst_n,
	input wire instr_valid,
	input wire [`DSP_DATA_W-1:0] instr,
	output logic [`DSP_DATA_W-1:0] bus_do,
	output logic bus_do_valid,
	output logic s_flag,
	output logic z_flag,
	output logic c_flag,
	output logic v_flag
);

	import dsp_pkg::*;

	data_t x_data;
	data_t y_data;
	data_t md_d1;
	data_t d1_value;	// Shared D1 bus.
	acc_t acc;
	flags_t flags;

	dsp_ctrl_if ctrl_if (.clock(clock));

	dsp_decoder decoder_inst (
		.instr_valid(instr_valid),
		.instr(instr),
		.ctrl(ctrl_if.dec)
	);

	dsp_ram_bank ram_inst (
		.clock(clock),
		.arst_n(arst_n),
		.ctrl(ctrl_if.ram),
		.d1_value(d1_value),
		.x_data(x_data),
		.y_data(y_data),
		.md_d1(md_d1)
	);

	dsp_mac mac_inst (
		.clock(clock),
		.arst_n(arst_n),
		.ctrl(ctrl_if.mac),
		.x_data(x_data),
		.y_data(y_data),
		.d1_value(d1_value),
		.acc(acc),
		.flags(flags)
	);

	dsp_d1_bus d1_inst (
		.clock(clock),
		.arst_n(arst_n),
		.ctrl(ctrl_if.d1),
		.md_d1(md_d1),
		.acc(acc),
		.d1_value(d1_value),
		.bus_do(bus_do),
		.bus_do_valid(bus_do_valid)
	);

	assign s_flag = flags.s;
	assign z_flag = flags.z;
	assign c_flag = flags.c;
	assign v_flag = flags.v;

endmodule

`default_nettype wire

// File: verilog/dsp_d1_bus.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsp_consts.svh"

module dsp_d1_bus (
	input wire clock,
	input wire arst_n,
	dsp_ctrl_if.d1 ctrl,
	input wire dsp_pkg::data_t md_d1,
	input wire dsp_pkg::acc_t acc,
	output dsp_pkg::data_t d1_value,
	output dsp_pkg::data_t bus_do,
	output logic bus_do_valid
);

	import dsp_pkg::*;

	always_comb begin
		case (ctrl.d1_src)
			D1S_MD0, D1S_MD1, D1S_MD2, D1S_MD3,
			D1S_MC0, D1S_MC1, D1S_MC2, D1S_MC3: d1_value = md_d1;
			D1S_ACL: d1_value = acc[`DSP_DATA_W-1:0];
			D1S_ACH: d1_value = {{(2*`DSP_DATA_W-`DSP_ACC_W){1'b0}}, acc[`DSP_ACC_W-1:`DSP_DATA_W]};
			default: d1_value = ctrl.imm;	// Immediate, or zero for no source.
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			bus_do_valid <= 1'b0;
		else
			bus_do_valid <= ctrl.d1_active;
	end

	always_ff @(posedge clock) begin
		if (ctrl.d1_active)
			bus_do <= d1_value;
	end

endmodule

`default_nettype wire

// File: verilog/dsp_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsp_consts.svh"

module dsp_decoder (
	input wire instr_valid,
	input wire dsp_pkg::data_t instr,
	dsp_ctrl_if.dec ctrl
);

	import dsp_pkg::*;

	logic op_word;
	logic [3:0] alu_f;
	logic [5:0] x_f;
	logic [5:0] y_f;
	logic [1:0] d1_f;
	logic [3:0] dst_f;
	logic [3:0] src_f;
	logic [7:0] imm_f;

	assign op_word = instr_valid && (instr[`DSP_CLASS_HI:`DSP_CLASS_LO] == `DSP_CLASS_OP);
	assign alu_f = instr[`DSP_ALU_HI:`DSP_ALU_LO];
	assign x_f = instr[`DSP_X_HI:`DSP_X_LO];
	assign y_f = instr[`DSP_Y_HI:`DSP_Y_LO];
	assign d1_f = instr[`DSP_D1_HI:`DSP_D1_LO];
	assign dst_f = instr[`DSP_D1_DST_HI:`DSP_D1_DST_LO];
	assign src_f = instr[`DSP_D1_SRC_HI:`DSP_D1_SRC_LO];
	assign imm_f = instr[`DSP_IMM_HI:`DSP_IMM_LO];

	always_comb begin
		ctrl.alu_op = ALU_NOP;
		ctrl.x_op = X_NOP;
		ctrl.x_ram = x_f[1:0];
		ctrl.x_inc = 1'b0;
		ctrl.y_op = Y_NOP;
		ctrl.y_ram = y_f[1:0];
		ctrl.y_inc = 1'b0;
		ctrl.d1_active = 1'b0;
		ctrl.d1_src = D1S_NONE;
		ctrl.d1_dst = D1_MD0;	// Ignored while D1 idle.
		ctrl.imm = '0;
		if (op_word) begin
			case (alu_f)
				4'h7, 4'hC, 4'hD, 4'hE: ctrl.alu_op = ALU_NOP;	// Unused codes.
				default: ctrl.alu_op = alu_op_e'(alu_f);
			endcase
			case (x_f[5:3])
				X_MUL_P: ctrl.x_op = X_MUL_P;
				X_MEM_P, X_MEM_X: begin
					ctrl.x_op = x_op_e'(x_f[5:3]);
					ctrl.x_inc = x_f[2];
				end
				default: ;
			endcase
			case (y_f[5:3])
				Y_CLR_A, Y_ALU_A: ctrl.y_op = y_op_e'(y_f[5:3]);
				Y_MEM_A, Y_MEM_Y: begin
					ctrl.y_op = y_op_e'(y_f[5:3]);
					ctrl.y_inc = y_f[2];
				end
				default: ;
			endcase
			case (d1_f)
				`DSP_D1_IMM: begin
					ctrl.d1_active = 1'b1;
					ctrl.d1_dst = d1_dst_e'(dst_f);
					ctrl.imm = {{(`DSP_DATA_W-8){imm_f[7]}}, imm_f};	// Sign extend.
				end
				`DSP_D1_MOV: begin
					ctrl.d1_active = 1'b1;
					ctrl.d1_dst = d1_dst_e'(dst_f);
					if (src_f <= D1S_ACH)
						ctrl.d1_src = d1_src_e'(src_f);
				end
				default: ;
			endcase
		end
	end

	assign ctrl.alu_valid = (ctrl.alu_op != ALU_NOP);

	// The MAC takes a single writer for RX and for PL in any word.
	assert property (@(posedge ctrl.clock)
		!(ctrl.d1_active && (((ctrl.x_op inside {X_MUL_P, X_MEM_P}) && ctrl.d1_dst == D1_PL) ||
		(ctrl.x_op == X_MEM_X && ctrl.d1_dst == D1_RX))));

endmodule

`default_nettype wire

// File: ram/dsp_ram_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsp_consts.svh"

module dsp_ram_bank (
	input wire clock,
	input wire arst_n,
	dsp_ctrl_if.ram ctrl,
	input wire dsp_pkg::data_t d1_value,
	output dsp_pkg::data_t x_data,
	output dsp_pkg::data_t y_data,
	output dsp_pkg::data_t md_d1
);

	import dsp_pkg::*;

	data_t mem [`DSP_NUM_RAMS][`DSP_RAM_DEPTH];	// MD0 to MD3.
	ct_t ct [`DSP_NUM_RAMS];
	logic [`DSP_NUM_RAMS-1:0] md_wr;
	logic [`DSP_NUM_RAMS-1:0] ct_load;
	logic [`DSP_NUM_RAMS-1:0] ct_inc;
	logic [3:0] src_code;
	logic [3:0] dst_code;
	ram_sel_t src_ram;
	logic src_is_md;

	assign src_code = ctrl.d1_src;
	assign dst_code = ctrl.d1_dst;
	assign src_ram = src_code[1:0];
	assign src_is_md = !src_code[3];	// NONE while D1 idle.

	always_comb begin
		for (int n = 0; n < `DSP_NUM_RAMS; n++) begin
			md_wr[n] = ctrl.d1_active && (dst_code == n);
			ct_load[n] = ctrl.d1_active && (dst_code == D1_CT0 + n);
			// All requests on one RAM merge into a single step.
			ct_inc[n] = (ctrl.x_inc && ctrl.x_ram == n) ||
				(ctrl.y_inc && ctrl.y_ram == n) ||
				(src_is_md && src_code[2] && src_ram == n) ||
				md_wr[n];
		end
	end

	assign x_data = mem[ctrl.x_ram][ct[ctrl.x_ram]];
	assign y_data = mem[ctrl.y_ram][ct[ctrl.y_ram]];
	assign md_d1 = mem[src_ram][ct[src_ram]];

	always_ff @(posedge clock) begin
		for (int n = 0; n < `DSP_NUM_RAMS; n++) begin
			if (md_wr[n])
				mem[n][ct[n]] <= d1_value;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ct <= '{default: '0};
		end else begin
			for (int n = 0; n < `DSP_NUM_RAMS; n++) begin
				if (ct_load[n])
					ct[n] <= d1_value[`DSP_CT_W-1:0];	// Load wins.
				else if (ct_inc[n])
					ct[n] <= ct[n] + 1'b1;	// Wraps at 64.
			end
		end
	end

	// Words stored in the data RAMs are always defined.
	assert property (@(posedge clock) disable iff (!arst_n)
		(md_wr != '0) |-> !$isunknown(d1_value));

endmodule

`default_nettype wire

// File: mac/dsp_mac.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsp_consts.svh"

module dsp_mac (
	input wire clock,
	input wire arst_n,
	dsp_ctrl_if.mac ctrl,
	input wire dsp_pkg::data_t x_data,
	input wire dsp_pkg::data_t y_data,
	input wire dsp_pkg::data_t d1_value,
	output dsp_pkg::acc_t acc,
	output dsp_pkg::flags_t flags
);

	import dsp_pkg::*;

	data_t rx;
	data_t ry;
	acc_t p_reg;
	acc_t a_reg;
	acc_t alu_result;
	flags_t flags_next;
	logic signed [2*`DSP_DATA_W-1:0] product;
	logic d1_to_rx;
	logic d1_to_pl;
	logic v_update;

	assign product = $signed(rx) * $signed(ry);
	assign d1_to_rx = ctrl.d1_active && (ctrl.d1_dst == D1_RX);
	assign d1_to_pl = ctrl.d1_active && (ctrl.d1_dst == D1_PL);
	assign v_update = ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AD2};

	dsp_alu alu_inst (
		.a(a_reg),
		.p(p_reg),
		.op(ctrl.alu_op),
		.result(alu_result),
		.flags_next(flags_next)
	);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rx <= '0;
			ry <= '0;
			p_reg <= '0;
		end else begin
			if (ctrl.x_op == X_MEM_X)
				rx <= x_data;
			else if (d1_to_rx)
				rx <= d1_value;
			if (ctrl.y_op == Y_MEM_Y)
				ry <= y_data;
			if (ctrl.x_op == X_MUL_P)
				p_reg <= product[`DSP_ACC_W-1:0];
			else if (ctrl.x_op == X_MEM_P)
				p_reg <= acc_t'($signed(x_data));	// PL with PH as sign.
			else if (d1_to_pl)
				p_reg <= acc_t'($signed(d1_value));
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			a_reg <= '0;
		end else begin
			case (ctrl.y_op)
				Y_CLR_A: a_reg <= '0;
				Y_ALU_A: a_reg <= alu_result;
				Y_MEM_A: a_reg[`DSP_DATA_W-1:0] <= y_data;	// ACH kept.
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			flags <= '0;
		else if (ctrl.alu_valid)
			flags <= '{s: flags_next.s, z: flags_next.z, c: flags_next.c,
				v: v_update ? flags_next.v : flags.v};
	end

	assign acc = a_reg;

endmodule

`default_nettype wire

// File: mac/dsp_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsp_consts.svh"

module dsp_alu (
	input wire dsp_pkg::acc_t a,
	input wire dsp_pkg::acc_t p,
	input wire dsp_pkg::alu_op_e op,
	output dsp_pkg::acc_t result,
	output dsp_pkg::flags_t flags_next
);

	import dsp_pkg::*;

	localparam int MSB = `DSP_DATA_W - 1;
	localparam int AMSB = `DSP_ACC_W - 1;

	data_t acl;
	data_t pl;
	data_t r32;
	logic [`DSP_DATA_W:0] add32;
	logic [`DSP_DATA_W:0] sub32;
	logic [`DSP_ACC_W:0] add48;
	logic wide;	// AD2 uses all 48 bits.
	logic carry;
	logic ovf;

	assign acl = a[MSB:0];
	assign pl = p[MSB:0];
	assign add32 = {1'b0, acl} + {1'b0, pl};
	assign sub32 = {1'b0, acl} - {1'b0, pl};	// Top bit is the borrow.
	assign add48 = {1'b0, a} + {1'b0, p};

	always_comb begin
		r32 = acl;
		wide = 1'b0;
		carry = 1'b0;
		ovf = 1'b0;
		case (op)
			ALU_AND: r32 = acl & pl;
			ALU_OR: r32 = acl | pl;
			ALU_XOR: r32 = acl ^ pl;
			ALU_ADD: begin
				r32 = add32[MSB:0];
				carry = add32[MSB+1];
				ovf = (acl[MSB] == pl[MSB]) && (r32[MSB] != acl[MSB]);
			end
			ALU_SUB: begin
				r32 = sub32[MSB:0];
				carry = sub32[MSB+1];
				ovf = (acl[MSB] != pl[MSB]) && (r32[MSB] != acl[MSB]);
			end
			ALU_AD2: begin
				wide = 1'b1;
				carry = add48[AMSB+1];
				ovf = (a[AMSB] == p[AMSB]) && (add48[AMSB] != a[AMSB]);
			end
			ALU_SR: begin
				r32 = {acl[MSB], acl[MSB:1]};	// Arithmetic.
				carry = acl[0];
			end
			ALU_RR: begin
				r32 = {acl[0], acl[MSB:1]};
				carry = acl[0];
			end
			ALU_SL: begin
				r32 = {acl[MSB-1:0], 1'b0};
				carry = acl[MSB];
			end
			ALU_RL: begin
				r32 = {acl[MSB-1:0], acl[MSB]};
				carry = acl[MSB];
			end
			ALU_RL8: begin
				r32 = {acl[MSB-8:0], acl[MSB:MSB-7]};
				carry = acl[MSB];
			end
			default: ;	// NOP passes A through.
		endcase
	end

	assign result = wide ? add48[AMSB:0] : {a[AMSB:MSB+1], r32};
	assign flags_next = '{s: wide ? add48[AMSB] : r32[MSB],
		z: wide ? (add48[AMSB:0] == '0) : (r32 == '0), c: carry, v: ovf};

endmodule

`default_nettype wire

// File: common/dsp_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dsp_ctrl_if (input wire clock);

	import dsp_pkg::*;

	alu_op_e alu_op;
	logic alu_valid;	// Op is a used code.
	x_op_e x_op;
	ram_sel_t x_ram;
	logic x_inc;
	y_op_e y_op;
	ram_sel_t y_ram;
	logic y_inc;
	logic d1_active;
	d1_src_e d1_src;
	d1_dst_e d1_dst;
	data_t imm;	// Zero unless MOV SImm.

	modport dec (input clock, output alu_op, alu_valid, x_op, x_ram, x_inc,
		y_op, y_ram, y_inc, d1_active, d1_src, d1_dst, imm);

	modport ram (input x_ram, x_inc, y_ram, y_inc, d1_active, d1_src, d1_dst);

	modport mac (input alu_op, alu_valid, x_op, y_op, d1_active, d1_dst);

	modport d1 (input d1_active, d1_src, imm);

endinterface

`default_nettype wire

// File: common/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	`include "dsp_consts.svh"

	typedef logic [`DSP_DATA_W-1:0] data_t;
	typedef logic [`DSP_ACC_W-1:0] acc_t;	// ACH(16), ACL(32).
	typedef logic [`DSP_CT_W-1:0] ct_t;
	typedef logic [$clog2(`DSP_NUM_RAMS)-1:0] ram_sel_t;

	typedef enum logic [3:0] {
		ALU_NOP = 4'h0, ALU_AND = 4'h1, ALU_OR = 4'h2, ALU_XOR = 4'h3,
		ALU_ADD = 4'h4, ALU_SUB = 4'h5, ALU_AD2 = 4'h6, ALU_SR = 4'h8,
		ALU_RR = 4'h9, ALU_SL = 4'hA, ALU_RL = 4'hB, ALU_RL8 = 4'hF
	} alu_op_e;

	// Values match bits 25:23 of the word.
	typedef enum logic [2:0] {X_NOP = 3'b000, X_MUL_P = 3'b010, X_MEM_P = 3'b011,
		X_MEM_X = 3'b100} x_op_e;

	// Values match bits 19:17 of the word.
	typedef enum logic [2:0] {Y_NOP = 3'b000, Y_CLR_A = 3'b001, Y_ALU_A = 3'b010,
		Y_MEM_A = 3'b011, Y_MEM_Y = 3'b100} y_op_e;

	typedef enum logic [3:0] {
		D1S_MD0 = 4'h0, D1S_MD1 = 4'h1, D1S_MD2 = 4'h2, D1S_MD3 = 4'h3,
		D1S_MC0 = 4'h4, D1S_MC1 = 4'h5, D1S_MC2 = 4'h6, D1S_MC3 = 4'h7,
		D1S_NONE = 4'h8, D1S_ACL = 4'h9, D1S_ACH = 4'hA
	} d1_src_e;

	typedef enum logic [3:0] {
		D1_MD0 = 4'h0, D1_MD1 = 4'h1, D1_MD2 = 4'h2, D1_MD3 = 4'h3,
		D1_RX = 4'h4, D1_PL = 4'h5, D1_RA0 = 4'h6, D1_WA0 = 4'h7,
		D1_LOP = 4'hA, D1_TOP = 4'hB,
		D1_CT0 = 4'hC, D1_CT1 = 4'hD, D1_CT2 = 4'hE, D1_CT3 = 4'hF
	} d1_dst_e;

	typedef struct packed {
		logic s;
		logic z;
		logic c;
		logic v;
	} flags_t;

endpackage

`default_nettype wire

// File: common/dsp_consts.svh
`ifndef DSP_CONSTS_SVH
`define DSP_CONSTS_SVH

`define DSP_DATA_W     32	// Data word.
`define DSP_ACC_W      48	// A and P registers.
`define DSP_CT_W       6
`define DSP_RAM_DEPTH  64	// Words per data RAM.
`define DSP_NUM_RAMS   4

// Operation command word fields.
`define DSP_CLASS_HI   31
`define DSP_CLASS_LO   30
`define DSP_ALU_HI     29
`define DSP_ALU_LO     26
`define DSP_X_HI       25
`define DSP_X_LO       20
`define DSP_Y_HI       19
`define DSP_Y_LO       14
`define DSP_D1_HI      13
`define DSP_D1_LO      12
`define DSP_D1_DST_HI  11
`define DSP_D1_DST_LO  8
`define DSP_D1_SRC_HI  3
`define DSP_D1_SRC_LO  0
`define DSP_IMM_HI     7
`define DSP_IMM_LO     0

`define DSP_CLASS_OP   2'b00	// Operation command class.
`define DSP_D1_IMM     2'b01	// MOV SImm,[d].
`define DSP_D1_MOV     2'b11	// MOV [s],[d].

`endif
